/* rtl/ebusPkg.sv */
`default_nettype none

package ebusPkg;

  // Width of one data word on the diagnostic bus
  localparam int ebusDataWidth = 36;

  //////////////////////////////////////////////////
  // Diagnostic function codes as the front end sends them

  typedef enum logic [6:0] {
    stopClock    = 7'o000,
    startClock   = 7'o001,
    burst        = 7'o004,
    clrReset     = 7'o006,
    setReset     = 7'o007,
    ldBurstRh    = 7'o040,
    ldBurstLh    = 7'o041,
    clrBurstRh   = 7'o042,
    clrBurstLh   = 7'o043,
    clrSrcRate   = 7'o044,
    ldSrcRate    = 7'o045,
    clrCramAdrRh = 7'o051,
    clrCramAdrLh = 7'o052,
    ldCramAdrRh  = 7'o053,
    ldCramAdrLh  = 7'o054,
    rdClkStatus  = 7'o100,
    rdCramAdr    = 7'o101
  } tDiagFunc;

  //////////////////////////////////////////////////
  // Request and response payloads

  typedef struct packed {
    tDiagFunc                 func;
    logic [ebusDataWidth-1:0] data;
  } tDiagReq;

  typedef struct packed {
    logic [ebusDataWidth-1:0] data;
    logic                     err;
  } tDiagResp;

endpackage

`default_nettype wire

/* rtl/clkPkg.sv */
`default_nettype none

package clkPkg;

  // Burst counter is built from two equal halves
  localparam int burstHalfWidth = 4;
  localparam int burstWidth     = 2 * burstHalfWidth;

  // CRAM diagnostic address halves
  localparam int cramAdrRhWidth = 6;
  localparam int cramAdrLhWidth = 5;

  // Clock source field and rate divider counter
  localparam int clkSrcWidth = 2;
  localparam int divWidth    = 3;

  // One cycle enable every 2**rate clocks
  typedef logic [1:0] tClkRate;

  typedef enum logic [1:0] {
    clkStopped  = 2'd0,
    clkRunning  = 2'd1,
    clkBursting = 2'd2
  } tClkState;

  typedef struct packed {
    logic                   running;
    logic                   bursting;
    logic                   eboxReset;
    logic [clkSrcWidth-1:0] source;
    tClkRate                rate;
    logic [burstWidth-1:0]  burstCount;
  } tClkStatus;

  typedef struct packed {
    logic [cramAdrLhWidth-1:0] lh;
    logic [cramAdrRhWidth-1:0] rh;
  } tCramDiagAdr;

endpackage

`default_nettype wire

/* rtl/clkControl.sv */
`timescale 1ns/1ps
`default_nettype none

module clkControl (
  input  logic              top0,
  input  logic              rstN,
  input  logic              reqAccept,
  input  ebusPkg::tDiagReq  req,
  output clkPkg::tClkStatus clkStatus,
  output logic              eboxClkEn,
  output logic              eboxReset
);
  import ebusPkg::*;
  import clkPkg::*;

  tClkState               state;
  logic [divWidth-1:0]    divCnt;
  logic [divWidth-1:0]    divMax;
  logic                   divTick;
  logic [clkSrcWidth-1:0] source;
  tClkRate                rate;
  logic [burstWidth-1:0]  burstCnt;
  logic                   cmdStop;
  logic                   cmdStart;
  logic                   cmdBurst;
  logic                   burstWr;
  logic                   burstStep;

  assign cmdStop  = reqAccept && (req.func == stopClock);
  assign cmdStart = reqAccept && (req.func == startClock);
  assign cmdBurst = reqAccept && (req.func == burst);
  assign burstWr  = reqAccept &&
                    (req.func inside {ldBurstRh, ldBurstLh, clrBurstRh, clrBurstLh});

  //////////////////////////////////////////////////
  // Rate divider

  assign divMax    = divWidth'((32'd1 << rate) - 32'd1);
  // >= covers a rate drop while the counter is past the new limit
  assign divTick   = (divCnt >= divMax);
  assign eboxClkEn = (state != clkStopped) && divTick;
  assign burstStep = (state == clkBursting) && eboxClkEn && (burstCnt != '0);

  always_ff @(posedge top0 or negedge rstN) begin
    if (!rstN) begin
      divCnt <= '0;
    end else if (cmdStart || cmdBurst || state == clkStopped || divTick) begin
      divCnt <= '0;
    end else begin
      divCnt <= divCnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Run / stop / burst FSM

  always_ff @(posedge top0 or negedge rstN) begin
    if (!rstN) begin
      state <= clkStopped;
    end else if (cmdStop) begin
      state <= clkStopped;
    end else if (cmdStart) begin
      state <= clkRunning;
    end else if (cmdBurst) begin
      // Zero count finishes immediately
      state <= (burstCnt == '0) ? clkStopped : clkBursting;
    end else if (state == clkBursting && eboxClkEn && burstCnt <= burstWidth'(1)) begin
      state <= clkStopped;
    end
  end

  // Burst counter halves, counted down by each burst pulse
  always_ff @(posedge top0 or negedge rstN) begin
    if (!rstN) begin
      burstCnt <= '0;
    end else if (burstWr) begin
      case (req.func)
        ldBurstRh:  burstCnt[burstHalfWidth-1:0] <= req.data[burstHalfWidth-1:0];
        ldBurstLh:  burstCnt[burstWidth-1:burstHalfWidth] <= req.data[burstHalfWidth-1:0];
        clrBurstRh: burstCnt[burstHalfWidth-1:0] <= '0;
        default:    burstCnt[burstWidth-1:burstHalfWidth] <= '0;
      endcase
    end else if (burstStep) begin
      burstCnt <= burstCnt - 1'b1;
    end
  end

  // Reset flag, source and rate
  always_ff @(posedge top0 or negedge rstN) begin
    if (!rstN) begin
      eboxReset <= 1'b1;
      source    <= '0;
      rate      <= '0;
    end else if (reqAccept) begin
      case (req.func)
        setReset: eboxReset <= 1'b1;
        clrReset: eboxReset <= 1'b0;
        ldSrcRate: begin
          rate   <= req.data[$bits(tClkRate)-1:0];
          source <= req.data[$bits(tClkRate) +: clkSrcWidth];
        end
        clrSrcRate: begin
          rate   <= '0;
          source <= '0;
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    clkStatus.running    = (state == clkRunning);
    clkStatus.bursting   = (state == clkBursting);
    clkStatus.eboxReset  = eboxReset;
    clkStatus.source     = source;
    clkStatus.rate       = rate;
    clkStatus.burstCount = burstCnt;
  end

endmodule

`default_nettype wire

/* rtl/crmDiagAddr.sv */
`timescale 1ns/1ps
`default_nettype none

module crmDiagAddr (
  input  logic                top0,
  input  logic                rstN,
  input  logic                reqAccept,
  input  ebusPkg::tDiagReq    req,
  output clkPkg::tCramDiagAdr cramAdr
);
  import ebusPkg::*;
  import clkPkg::*;

  logic [cramAdrRhWidth-1:0] adrRh;
  logic [cramAdrLhWidth-1:0] adrLh;

  //////////////////////////////////////////////////
  // Right half

  always_ff @(posedge top0 or negedge rstN) begin
    if (!rstN) begin
      adrRh <= '0;
    end else if (reqAccept) begin
      if (req.func == ldCramAdrRh) begin
        adrRh <= req.data[cramAdrRhWidth-1:0];
      end else if (req.func == clrCramAdrRh) begin
        adrRh <= '0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Left half, also loaded from the low data bits

  always_ff @(posedge top0 or negedge rstN) begin
    if (!rstN) begin
      adrLh <= '0;
    end else if (reqAccept) begin
      if (req.func == ldCramAdrLh) begin
        adrLh <= req.data[cramAdrLhWidth-1:0];
      end else if (req.func == clrCramAdrLh) begin
        adrLh <= '0;
      end
    end
  end

  assign cramAdr.lh = adrLh;
  assign cramAdr.rh = adrRh;

endmodule

`default_nettype wire

/* rtl/diagResponse.sv */
`timescale 1ns/1ps
`default_nettype none

module diagResponse (
  input  logic                top0,
  input  logic                rstN,
  input  logic                reqValid,
  output logic                reqReady,
  input  ebusPkg::tDiagReq    req,
  output logic                reqAccept,
  input  clkPkg::tClkStatus   clkStatus,
  input  clkPkg::tCramDiagAdr cramAdr,
  output logic                respValid,
  input  logic                respReady,
  output ebusPkg::tDiagResp   resp
);
  import ebusPkg::*;

  tDiagResp respNext;

  // Free when empty or when the held response leaves this cycle
  assign reqReady  = !respValid || respReady;
  assign reqAccept = reqValid && reqReady;

  //////////////////////////////////////////////////
  // Response decode

  // Read codes never write, so current state already equals the post-edge view
  always_comb begin
    respNext = '0;
    case (req.func)
      rdClkStatus: respNext.data[$bits(clkStatus)-1:0] = clkStatus;
      rdCramAdr:   respNext.data[$bits(cramAdr)-1:0] = cramAdr;
      stopClock, startClock, burst, clrReset, setReset,
      ldBurstRh, ldBurstLh, clrBurstRh, clrBurstLh,
      clrSrcRate, ldSrcRate,
      clrCramAdrRh, clrCramAdrLh, ldCramAdrRh, ldCramAdrLh: ;
      // Anything else is flagged back to the front end
      default:     respNext.err = 1'b1;
    endcase
  end

  //////////////////////////////////////////////////
  // Single response slot

  always_ff @(posedge top0 or negedge rstN) begin
    if (!rstN) begin
      respValid <= 1'b0;
    end else if (reqAccept) begin
      respValid <= 1'b1;
    end else if (respReady) begin
      respValid <= 1'b0;
    end
  end

  always_ff @(posedge top0 or negedge rstN) begin
    if (!rstN) begin
      resp <= '0;
    end else if (reqAccept) begin
      resp <= respNext;
    end
  end

endmodule

`default_nettype wire

/* rtl/clkDiag.sv */
`timescale 1ns/1ps
`default_nettype none

module clkDiag (
  input  logic              top0,
  input  logic              rstN,
  input  logic              reqValid,
  output logic              reqReady,
  input  ebusPkg::tDiagReq  req,
  output logic              respValid,
  input  logic              respReady,
  output ebusPkg::tDiagResp resp,
  output logic              eboxClkEn,
  output logic              eboxReset
);
  import clkPkg::*;

  logic        reqAccept;
  tClkStatus   clkStatus;
  tCramDiagAdr cramAdr;

  // Clock run control and its registers
  clkControl clkControl0 (
    .top0      (top0),
    .rstN      (rstN),
    .reqAccept (reqAccept),
    .req       (req),
    .clkStatus (clkStatus),
    .eboxClkEn (eboxClkEn),
    .eboxReset (eboxReset)
  );

  crmDiagAddr crmDiagAddr0 (
    .top0      (top0),
    .rstN      (rstN),
    .reqAccept (reqAccept),
    .req       (req),
    .cramAdr   (cramAdr)
  );

  // Owns the handshake on both channels
  diagResponse diagResponse0 (
    .top0      (top0),
    .rstN      (rstN),
    .reqValid  (reqValid),
    .reqReady  (reqReady),
    .req       (req),
    .reqAccept (reqAccept),
    .clkStatus (clkStatus),
    .cramAdr   (cramAdr),
    .respValid (respValid),
    .respReady (respReady),
    .resp      (resp)
  );

endmodule

`default_nettype wire

/* tests/clkDiagTb.sv */
`timescale 1ns/1ps
`default_nettype none

module clkDiagTb;
  import ebusPkg::*;
  import clkPkg::*;

  // Longest burst is 255 pulses at rate 0, all other tests stay well below 600 cycles
  localparam int timeoutCycles = 2000;

  logic      top0;
  logic      rstN;
  logic      reqValid;
  logic      reqReady;
  tDiagReq   req;
  logic      respValid;
  logic      respReady;
  tDiagResp  resp;
  logic      eboxClkEn;
  logic      eboxReset;

  integer    seed;
  int        cycleCount = 0;
  int        errCount = 0;
  int        testsFailed = 0;
  int        pulseCount = 0;
  tClkStatus expStat;
  tDiagResp  respLog[$];

  clkDiag i_clkDiag (
    .top0      (top0),
    .rstN      (rstN),
    .reqValid  (reqValid),
    .reqReady  (reqReady),
    .req       (req),
    .respValid (respValid),
    .respReady (respReady),
    .resp      (resp),
    .eboxClkEn (eboxClkEn),
    .eboxReset (eboxReset)
  );

  initial begin
    top0 = 1'b0;
    forever #5 top0 = ~top0;
  end

  //////////////////////////////////////////////////
  // Monitors, sampled on the falling edge

  always @(negedge top0) begin
    if (eboxClkEn) begin
      pulseCount++;
    end
    // Handshake completes on the next rising edge
    if (respValid && respReady) begin
      respLog.push_back(resp);
    end
  end

  always @(posedge top0) begin
    cycleCount++;
    if (cycleCount >= timeoutCycles) begin
      $display("Timeout after %0d cycles, a test never finished", cycleCount);
      $display("Test FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Driver and compare tasks

  function automatic tDiagReq makeReq(input tDiagFunc func, input logic [35:0] data);
    tDiagReq r;
    r.func = func;
    r.data = data;
    return r;
  endfunction

  function automatic string statusText(input tClkStatus s);
    return $sformatf("run=%b bst=%b rst=%b src=%0d rate=%0d cnt=%0d",
                     s.running, s.bursting, s.eboxReset, s.source, s.rate, s.burstCount);
  endfunction

  task automatic reportFail(input string msg);
    errCount++;
    $display("%s", msg);
  endtask

  // Send one request, then wait for its response
  task automatic doDiagFunc(input tDiagFunc func, input logic [35:0] data,
                            output tDiagResp got);
    @(posedge top0);
    reqValid  <= 1'b1;
    req       <= makeReq(func, data);
    respReady <= 1'b1;
    @(negedge top0);
    while (!reqReady) @(negedge top0);
    @(posedge top0);
    reqValid <= 1'b0;
    @(negedge top0);
    while (!respValid) @(negedge top0);
    got = resp;
  endtask

  task automatic checkResp(input string name, input tDiagResp exp, input tDiagResp got);
    if (got !== exp) begin
      reportFail($sformatf("ERROR %s: expected data=%h err=%b, actual data=%h err=%b",
                           name, exp.data, exp.err, got.data, got.err));
    end
  endtask

  task automatic checkStatus(input string name, input tClkStatus exp, input tDiagResp got);
    tClkStatus act;
    act = got.data[$bits(tClkStatus)-1:0];
    if (got.err !== 1'b0 || got.data !== ebusDataWidth'(exp)) begin
      reportFail($sformatf("ERROR %s: expected %s, actual %s err=%b data=%h",
                           name, statusText(exp), statusText(act), got.err, got.data));
    end
  endtask

  task automatic expectStatus(input string name);
    tDiagResp got;
    doDiagFunc(rdClkStatus, '0, got);
    checkStatus(name, expStat, got);
  endtask

  task automatic expectCram(input string name, input tCramDiagAdr adr);
    tDiagResp got;
    tDiagResp exp;
    exp = '0;
    exp.data = ebusDataWidth'(adr);
    doDiagFunc(rdCramAdr, '0, got);
    checkResp(name, exp, got);
  endtask

  task automatic finishTest(input string name, input int errStart);
    if (errCount == errStart) begin
      $display("PASS %s", name);
    end else begin
      testsFailed++;
      $display("FAIL %s with %0d errors", name, errCount - errStart);
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests

  task automatic resetTest();
    int errStart;
    tDiagResp got;
    errStart = errCount;
    repeat (10) begin
      @(negedge top0);
      if (eboxClkEn !== 1'b0 || eboxReset !== 1'b1) begin
        reportFail($sformatf("ERROR reset: expected clkEn=0 eboxReset=1, actual %b %b",
                             eboxClkEn, eboxReset));
      end
    end
    expStat = '0;
    expStat.eboxReset = 1'b1;
    expectStatus("reset status");
    doDiagFunc(clrReset, '0, got);
    if (eboxReset !== 1'b0) begin
      reportFail($sformatf("ERROR clrReset: expected eboxReset 0, actual %b", eboxReset));
    end
    doDiagFunc(setReset, '0, got);
    if (eboxReset !== 1'b1) begin
      reportFail($sformatf("ERROR setReset: expected eboxReset 1, actual %b", eboxReset));
    end
    finishTest("reset", errStart);
  endtask

  task automatic rateTest();
    int errStart;
    int lastPulse;
    int pulses;
    int i;
    logic [31:0] rnd;
    tDiagResp got;
    errStart = errCount;
    rnd = $random(seed);
    // Rate sits in bits 1:0 and source in bits 3:2
    expStat.rate   = rnd[1:0];
    expStat.source = rnd[3:2];
    doDiagFunc(ldSrcRate, {4'h0, rnd}, got);
    expectStatus("source/rate load");
    doDiagFunc(startClock, '0, got);
    lastPulse = -1;
    pulses = 0;
    for (i = 0; i < 40; i++) begin
      @(negedge top0);
      if (eboxClkEn) begin
        if (lastPulse >= 0 && i - lastPulse != (1 << expStat.rate)) begin
          reportFail($sformatf("ERROR rate gap: expected %0d, actual %0d",
                               1 << expStat.rate, i - lastPulse));
        end
        lastPulse = i;
        pulses++;
      end
    end
    if (pulses < 4) begin
      reportFail($sformatf("Only %0d clock enable pulses in 40 cycles while running", pulses));
    end
    expStat.running = 1'b1;
    expectStatus("running status");
    doDiagFunc(stopClock, '0, got);
    expStat.running = 1'b0;
    pulses = 0;
    repeat (20) begin
      @(negedge top0);
      pulses += int'(eboxClkEn);
    end
    if (pulses != 0) begin
      reportFail($sformatf("Clock enable pulsed %0d times after stopClock", pulses));
    end
    expectStatus("stopped status");
    doDiagFunc(clrSrcRate, '0, got);
    expStat.rate   = '0;
    expStat.source = '0;
    expectStatus("clrSrcRate");
    finishTest("rate", errStart);
  endtask

  task automatic burstTest();
    int errStart;
    int expPulses;
    logic [31:0] rnd;
    tDiagResp got;
    errStart = errCount;
    rnd = $random(seed);
    doDiagFunc(ldBurstRh, {4'h0, rnd}, got);
    doDiagFunc(ldBurstLh, {4'h0, rnd >> 4}, got);
    expStat.burstCount = {rnd[7:4], rnd[3:0]};
    expectStatus("burst load");
    expPulses = int'(rnd[7:4]) * 16 + int'(rnd[3:0]);
    @(posedge top0);
    pulseCount = 0;
    doDiagFunc(burst, '0, got);
    // Burst length is fixed at count times 2**rate clocks
    repeat (expPulses * (1 << expStat.rate) + 8) @(negedge top0);
    if (pulseCount != expPulses) begin
      reportFail($sformatf("ERROR burst pulses: expected %0d, actual %0d",
                           expPulses, pulseCount));
    end
    expStat.burstCount = '0;
    expectStatus("burst done");
    rnd = $random(seed);
    doDiagFunc(ldBurstRh, {4'h0, rnd}, got);
    doDiagFunc(ldBurstLh, {4'h0, rnd >> 4}, got);
    doDiagFunc(clrBurstRh, '0, got);
    expStat.burstCount = {rnd[7:4], 4'h0};
    expectStatus("clrBurstRh");
    doDiagFunc(ldBurstRh, {4'h0, rnd}, got);
    doDiagFunc(clrBurstLh, '0, got);
    expStat.burstCount = {4'h0, rnd[3:0]};
    expectStatus("clrBurstLh");
    doDiagFunc(clrBurstRh, '0, got);
    expStat.burstCount = '0;
    finishTest("burst", errStart);
  endtask

  task automatic cramTest();
    int errStart;
    logic [31:0] rnd;
    tCramDiagAdr expAdr;
    tDiagResp got;
    errStart = errCount;
    rnd = $random(seed);
    expAdr.rh = rnd[5:0];
    expAdr.lh = rnd[10:6];
    doDiagFunc(ldCramAdrRh, {4'h0, rnd}, got);
    doDiagFunc(ldCramAdrLh, {4'h0, rnd >> 6}, got);
    expectCram("cram load", expAdr);
    doDiagFunc(clrCramAdrRh, '0, got);
    expAdr.rh = '0;
    expectCram("clrCramAdrRh", expAdr);
    doDiagFunc(ldCramAdrRh, {4'h0, rnd}, got);
    doDiagFunc(clrCramAdrLh, '0, got);
    expAdr.rh = rnd[5:0];
    expAdr.lh = '0;
    expectCram("clrCramAdrLh", expAdr);
    finishTest("cram", errStart);
  endtask

  task automatic codeTest();
    int errStart;
    tDiagFunc f;
    tDiagResp exp;
    tDiagResp got;
    errStart = errCount;
    exp = '0;
    exp.err = 1'b1;
    doDiagFunc(tDiagFunc'(7'o077), '0, got);
    checkResp("unknown code 077", exp, got);
    // Zero data on every code leaves the block stopped, in reset, all registers clear
    exp = '0;
    f = f.first();
    repeat (f.num()) begin
      doDiagFunc(f, '0, got);
      if (f == rdClkStatus) begin
        checkStatus($sformatf("code %s", f.name()), expStat, got);
      end else begin
        checkResp($sformatf("code %s", f.name()), exp, got);
      end
      f = f.next();
    end
    finishTest("codes", errStart);
  endtask

  task automatic backPressureTest();
    int errStart;
    int logBase;
    logic [31:0] rnd;
    tCramDiagAdr adr;
    tDiagResp expA;
    tDiagResp expB;
    tDiagResp got;
    errStart = errCount;
    rnd = $random(seed);
    doDiagFunc(ldCramAdrRh, {4'h0, rnd}, got);
    adr = '0;
    adr.rh = rnd[5:0];
    expA = '0;
    expA.data = ebusDataWidth'(expStat);
    expB = '0;
    expB.data = ebusDataWidth'(adr);
    @(posedge top0);
    logBase = respLog.size();
    respReady <= 1'b0;
    reqValid  <= 1'b1;
    req       <= makeReq(rdClkStatus, '0);
    @(negedge top0);
    while (!reqReady) @(negedge top0);
    @(posedge top0);
    req <= makeReq(rdCramAdr, '0);
    repeat (4) begin
      @(negedge top0);
      if (respValid !== 1'b1 || reqReady !== 1'b0) begin
        reportFail("Held response dropped or reqReady raised under back-pressure");
      end
      checkResp("held response", expA, resp);
    end
    @(posedge top0);
    respReady <= 1'b1;
    @(negedge top0);
    while (!reqReady) @(negedge top0);
    @(posedge top0);
    reqValid <= 1'b0;
    repeat (3) @(negedge top0);
    if (respLog.size() != logBase + 2) begin
      reportFail($sformatf("Expected 2 responses after release, got %0d",
                           respLog.size() - logBase));
    end else begin
      checkResp("first released", expA, respLog[logBase]);
      checkResp("second released", expB, respLog[logBase + 1]);
    end
    finishTest("backPressure", errStart);
  endtask

  initial begin
    rstN      = 1'b0;
    reqValid  = 1'b0;
    respReady = 1'b1;
    req       = '0;
    seed      = 32'hbf88;
    repeat (5) @(posedge top0);
    rstN <= 1'b1;
    resetTest();
    rateTest();
    burstTest();
    cramTest();
    codeTest();
    backPressureTest();
    $display("Summary: 6 tests, %0d failed, %0d errors", testsFailed, errCount);
    if (errCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* clkDiag.f */
rtl/ebusPkg.sv
rtl/clkPkg.sv
rtl/clkControl.sv
rtl/crmDiagAddr.sv
rtl/diagResponse.sv
rtl/clkDiag.sv
tests/clkDiagTb.sv

/* Makefile */
TOP := clkDiagTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f clkDiag.f --top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

lint:
	verilator --lint-only --timing -Wall -f clkDiag.f --top-module $(TOP)

clean:
	rm -rf obj_dir
